// ==== logic/soc_mem_pkg.sv ====
`default_nettype none

package soc_mem_pkg;

	// display timing in pixel clocks and lines.
	localparam int H_ACTIVE     = 128;
	localparam int H_TOTAL      = 160;
	localparam int H_SYNC_START = 136;
	localparam int H_SYNC_END   = 152;

	localparam int V_ACTIVE     = 96;
	localparam int V_TOTAL      = 104;
	localparam int V_SYNC_START = 98;
	localparam int V_SYNC_END   = 100;

	localparam int FRAME_BYTES  = 1536; // frame buffer sits just below the top of memory.
	localparam int UART_OFFSET  = 4;    // status word is the last word of memory.
	localparam int BAUD_DIV     = 16;   // clocks per serial bit.

	typedef enum logic {
		SRC_CPU = 1'b0,
		SRC_VGA = 1'b1
	} src_e;

	typedef struct packed {
		logic        write;
		logic [31:0] adr;
		logic [31:0] wdata;
		logic [3:0]  sel;
	} cpu_req_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] rdata;
	} cpu_rsp_t;

	// one access as it moves from the arbiter to the bus.
	typedef struct packed {
		src_e        src;
		logic        write;
		logic        uart_hit;
		logic [31:0] adr;
		logic [31:0] wdata;
		logic [3:0]  sel;
	} mem_op_t;

	typedef struct packed {
		src_e        src;
		logic        uart_hit; // set only for a uart read.
		logic [31:0] rdata;
	} mem_done_t;

	typedef struct packed {
		logic       is_new;
		logic [7:0] data;
	} uart_stat_t;

endpackage

`default_nettype wire

// ==== logic/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
	input  logic                    mem_read,
	input  logic                    arst_n,
	input  logic                    rx,
	output soc_mem_pkg::uart_stat_t uart_stat,
	input  logic                    uart_rd_ack
);
	import soc_mem_pkg::*;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	rx_state_e                     state;
	logic [1:0]                    sync_q;
	logic                          rx_s;
	logic [$clog2(BAUD_DIV)-1:0]   baud_cnt;
	logic [2:0]                    bit_cnt;
	logic [7:0]                    shift_q;
	logic                          half_tick;
	logic                          bit_tick;
	logic                          got_byte;
	logic                          flag_q;
	logic [7:0]                    byte_q;

	assign rx_s      = sync_q[1];
	assign half_tick = (baud_cnt == BAUD_DIV / 2 - 1);
	assign bit_tick  = (baud_cnt == BAUD_DIV - 1);
	assign got_byte  = (state == RX_STOP) && bit_tick && rx_s; // bad stop bit drops the frame.

	always_ff @(posedge mem_read or negedge arst_n) begin
		if (!arst_n) begin
			sync_q   <= 2'b11; // line idles high.
			state    <= RX_IDLE;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			flag_q   <= 1'b0;
			byte_q   <= '0;
		end else begin
			sync_q <= {sync_q[0], rx};
			case (state)
				RX_IDLE: begin
					baud_cnt <= '0;
					if (!rx_s)
						state <= RX_START;
				end
				RX_START: begin
					baud_cnt <= baud_cnt + 1'b1;
					if (half_tick) begin
						baud_cnt <= '0;
						bit_cnt  <= '0;
						state    <= rx_s ? RX_IDLE : RX_DATA; // glitch returns to idle.
					end
				end
				RX_DATA: begin
					baud_cnt <= baud_cnt + 1'b1;
					if (bit_tick) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= RX_STOP;
					end
				end
				default: begin
					baud_cnt <= baud_cnt + 1'b1;
					if (bit_tick)
						state <= RX_IDLE;
				end
			endcase
			if (got_byte) begin
				byte_q <= shift_q;
				flag_q <= 1'b1; // a fresh byte wins over a read in the same cycle.
			end else if (uart_rd_ack) begin
				flag_q <= 1'b0;
			end
		end
	end

	// lsb arrives first.
	always_ff @(posedge mem_read) begin
		if (state == RX_DATA && bit_tick)
			shift_q <= {rx_s, shift_q[7:1]};
	end

	assign uart_stat = '{is_new: flag_q, data: byte_q};

endmodule

`default_nettype wire

// ==== logic/vga_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_fetch (
	input  logic        mem_read,
	input  logic        arst_n,
	output logic        vga_req_valid,
	output logic [8:0]  vga_word,
	input  logic        vga_req_ack,
	input  logic        vga_rsp_valid,
	input  logic [31:0] vga_rsp_data,
	output logic        hsync_n,
	output logic        vsync_n,
	output logic        pixel_data
);
	import soc_mem_pkg::*;

	logic [7:0]  h_cnt;
	logic [6:0]  v_cnt;
	logic [6:0]  v_next;
	logic        active;
	logic        grp_start;
	logic        fetch_now;
	logic [8:0]  fetch_word;
	logic        started;
	logic        pf_full;
	logic [31:0] pf_data;
	logic [31:0] shift_q;

	assign active    = (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);
	assign grp_start = active && (h_cnt[4:0] == 5'd0);
	assign v_next    = (v_cnt == V_TOTAL - 1) ? 7'd0 : v_cnt + 7'd1;

	// word index is line * 4 + group, so it packs as {line, group}.
	always_comb begin
		fetch_now  = 1'b0;
		fetch_word = {v_next, 2'd0};
		if (grp_start && h_cnt[6:5] != 2'd3) begin
			fetch_now  = 1'b1;
			fetch_word = {v_cnt, h_cnt[6:5] + 2'd1};
		end else if (h_cnt == H_ACTIVE && v_next < V_ACTIVE) begin
			fetch_now  = 1'b1; // first group of the next line.
		end
	end

	always_ff @(posedge mem_read or negedge arst_n) begin
		if (!arst_n) begin
			h_cnt         <= '0;
			v_cnt         <= '0;
			started       <= 1'b0;
			hsync_n       <= 1'b1;
			vsync_n       <= 1'b1;
			pixel_data    <= 1'b0;
			pf_full       <= 1'b0;
			vga_req_valid <= 1'b0;
		end else begin
			started <= 1'b1;
			h_cnt   <= (h_cnt == H_TOTAL - 1) ? 8'd0 : h_cnt + 8'd1;
			if (h_cnt == H_TOTAL - 1)
				v_cnt <= v_next;
			hsync_n <= !(h_cnt >= H_SYNC_START && h_cnt < H_SYNC_END);
			vsync_n <= !(v_cnt >= V_SYNC_START && v_cnt < V_SYNC_END);
			if (grp_start)
				pixel_data <= started && pf_data[0];
			else
				pixel_data <= active && shift_q[0];
			if (vga_rsp_valid)
				pf_full <= 1'b1;
			else if (grp_start)
				pf_full <= 1'b0;
			if (fetch_now)
				vga_req_valid <= 1'b1;
			else if (vga_req_ack)
				vga_req_valid <= 1'b0;
		end
	end

	// the group right after reset was never prefetched and shows blank.
	always_ff @(posedge mem_read) begin
		if (vga_rsp_valid)
			pf_data <= vga_rsp_data;
		if (grp_start)
			shift_q <= started ? (pf_data >> 1) : '0;
		else
			shift_q <= shift_q >> 1;
		if (fetch_now)
			vga_word <= fetch_word;
	end

	// the pipeline must return each word within the 32-cycle slack.
	a_prefetch_ready: assert property (@(posedge mem_read) disable iff (!arst_n)
		grp_start && started |-> pf_full);

endmodule

`default_nettype wire

// ==== logic/req_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module req_arbiter (
	input  logic                  mem_read,
	input  logic                  arst_n,
	input  logic [31:0]           mem_size,
	input  logic                  cpu_valid,
	input  soc_mem_pkg::cpu_req_t cpu_req,
	output logic                  cpu_ready,
	input  logic                  cpu_done,
	input  logic                  vga_req_valid,
	input  logic [8:0]            vga_word,
	output logic                  vga_req_ack,
	output logic                  op_valid,
	output soc_mem_pkg::mem_op_t  op,
	input  logic                  op_ready
);
	import soc_mem_pkg::*;

	logic    slot_free;
	logic    cpu_pend;
	logic    cpu_take;
	logic    take;
	mem_op_t op_next;

	assign slot_free   = !op_valid || op_ready; // output stage empties this edge.
	assign vga_req_ack = vga_req_valid && slot_free;
	assign cpu_ready   = slot_free && !cpu_pend && !vga_req_valid; // display goes first.
	assign cpu_take    = cpu_valid && cpu_ready;
	assign take        = vga_req_ack || cpu_take;

	always_comb begin
		if (vga_req_valid) begin
			op_next.src      = SRC_VGA;
			op_next.write    = 1'b0;
			op_next.uart_hit = 1'b0;
			op_next.adr      = mem_size - FRAME_BYTES + {21'd0, vga_word, 2'b00};
			op_next.wdata    = '0;
			op_next.sel      = 4'hf;
		end else begin
			op_next.src      = SRC_CPU;
			op_next.write    = cpu_req.write;
			op_next.uart_hit = (cpu_req.adr == mem_size - UART_OFFSET);
			op_next.adr      = cpu_req.adr;
			op_next.wdata    = cpu_req.wdata;
			op_next.sel      = cpu_req.sel;
		end
	end

	always_ff @(posedge mem_read or negedge arst_n) begin
		if (!arst_n) begin
			op_valid <= 1'b0;
			cpu_pend <= 1'b0;
		end else begin
			if (take)
				op_valid <= 1'b1;
			else if (op_ready)
				op_valid <= 1'b0;
			// one cpu request in flight until its response comes back.
			if (cpu_take)
				cpu_pend <= 1'b1;
			else if (cpu_done)
				cpu_pend <= 1'b0;
		end
	end

	always_ff @(posedge mem_read) begin
		if (take)
			op <= op_next;
	end

	a_op_hold: assert property (@(posedge mem_read) disable iff (!arst_n)
		op_valid && !op_ready |=> op_valid && $stable(op));

endmodule

`default_nettype wire

// ==== logic/mem_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_issue (
	input  logic                   mem_read,
	input  logic                   arst_n,
	input  logic                   op_valid,
	input  soc_mem_pkg::mem_op_t   op,
	output logic                   op_ready,
	output logic                   rd_en,
	output logic                   wr_en,
	output logic [31:0]            adr,
	output logic [31:0]            wdata,
	output logic [3:0]             sel,
	input  logic                   mem_busy,
	input  logic [31:0]            rdata,
	output logic                   done_valid,
	output soc_mem_pkg::mem_done_t done
);
	import soc_mem_pkg::*;

	logic    busy;
	logic    cpl;
	logic    accept;
	mem_op_t cur;

	// uart hits never touch the bus and finish in one cycle.
	assign cpl      = busy && (cur.uart_hit || !mem_busy);
	assign op_ready = !busy || cpl;
	assign accept   = op_valid && op_ready;

	assign rd_en = busy && !cur.uart_hit && !cur.write;
	assign wr_en = busy && !cur.uart_hit && cur.write;
	assign adr   = cur.adr;
	assign wdata = cur.wdata;
	assign sel   = cur.sel;

	always_ff @(posedge mem_read or negedge arst_n) begin
		if (!arst_n) begin
			busy       <= 1'b0;
			done_valid <= 1'b0;
		end else begin
			if (accept)
				busy <= 1'b1; // back to back when a new op arrives at completion.
			else if (cpl)
				busy <= 1'b0;
			done_valid <= cpl;
		end
	end

	always_ff @(posedge mem_read) begin
		if (accept)
			cur <= op;
		if (cpl) begin
			done.src <= cur.src;
			// a uart write is reported as a plain write, so it gets zero and no ack.
			done.uart_hit <= cur.uart_hit && !cur.write;
			done.rdata    <= (cur.write || cur.uart_hit) ? 32'd0 : rdata;
		end
	end

	a_one_strobe: assert property (@(posedge mem_read) disable iff (!arst_n)
		!(rd_en && wr_en));

	a_bus_hold: assert property (@(posedge mem_read) disable iff (!arst_n)
		(rd_en || wr_en) && mem_busy |=> $stable({rd_en, wr_en, adr, wdata, sel}));

endmodule

`default_nettype wire

// ==== logic/resp_route.sv ====
`timescale 1ns/1ps
`default_nettype none

module resp_route (
	input  logic                    mem_read,
	input  logic                    arst_n,
	input  logic                    done_valid,
	input  soc_mem_pkg::mem_done_t  done,
	input  soc_mem_pkg::uart_stat_t uart_stat,
	output logic                    uart_rd_ack,
	output soc_mem_pkg::cpu_rsp_t   cpu_rsp,
	output logic                    cpu_done,
	output logic                    vga_rsp_valid,
	output logic [31:0]             vga_rsp_data
);
	import soc_mem_pkg::*;

	logic        to_cpu;
	logic        to_vga;
	logic        rsp_valid_q;
	logic [31:0] rsp_data_q;

	assign to_cpu = done_valid && (done.src == SRC_CPU);
	assign to_vga = done_valid && (done.src == SRC_VGA);

	// ack in the cycle the status is sampled, so no byte slips past the read.
	assign uart_rd_ack = to_cpu && done.uart_hit;

	always_ff @(posedge mem_read or negedge arst_n) begin
		if (!arst_n) begin
			rsp_valid_q   <= 1'b0;
			vga_rsp_valid <= 1'b0;
		end else begin
			rsp_valid_q   <= to_cpu;
			vga_rsp_valid <= to_vga;
		end
	end

	always_ff @(posedge mem_read) begin
		if (to_cpu)
			rsp_data_q <= done.uart_hit ? {23'd0, uart_stat} : done.rdata;
		if (to_vga)
			vga_rsp_data <= done.rdata;
	end

	assign cpu_rsp  = '{valid: rsp_valid_q, rdata: rsp_data_q};
	assign cpu_done = rsp_valid_q; // frees the arbiter for the next cpu request.

endmodule

`default_nettype wire

// ==== logic/soc_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_mem_top (
	input  logic                  mem_read,
	input  logic                  arst_n,
	input  logic                  rx,
	input  logic [31:0]           mem_size,
	input  logic                  cpu_valid,
	input  soc_mem_pkg::cpu_req_t cpu_req,
	output logic                  cpu_ready,
	output soc_mem_pkg::cpu_rsp_t cpu_rsp,
	output logic                  rd_en,
	output logic                  wr_en,
	output logic [31:0]           adr,
	output logic [31:0]           wdata,
	output logic [3:0]            sel,
	input  logic                  mem_busy,
	input  logic [31:0]           rdata,
	output logic                  hsync_n,
	output logic                  vsync_n,
	output logic                  pixel_data
);
	import soc_mem_pkg::*;

	uart_stat_t  uart_stat;
	logic        uart_rd_ack;
	logic        vga_req_valid;
	logic [8:0]  vga_word;
	logic        vga_req_ack;
	logic        vga_rsp_valid;
	logic [31:0] vga_rsp_data;
	logic        op_valid;
	mem_op_t     op;
	logic        op_ready;
	logic        done_valid;
	mem_done_t   done;
	logic        cpu_done;

	uart_rx i_uart_rx (
		.mem_read, .arst_n, .rx, .uart_stat, .uart_rd_ack
	);

	vga_fetch i_vga_fetch (
		.mem_read, .arst_n, .vga_req_valid, .vga_word, .vga_req_ack,
		.vga_rsp_valid, .vga_rsp_data, .hsync_n, .vsync_n, .pixel_data
	);

	req_arbiter i_req_arbiter (
		.mem_read, .arst_n, .mem_size, .cpu_valid, .cpu_req, .cpu_ready, .cpu_done,
		.vga_req_valid, .vga_word, .vga_req_ack, .op_valid, .op, .op_ready
	);

	mem_issue i_mem_issue (
		.mem_read, .arst_n, .op_valid, .op, .op_ready, .rd_en, .wr_en, .adr, .wdata,
		.sel, .mem_busy, .rdata, .done_valid, .done
	);

	resp_route i_resp_route (
		.mem_read, .arst_n, .done_valid, .done, .uart_stat, .uart_rd_ack,
		.cpu_rsp, .cpu_done, .vga_rsp_valid, .vga_rsp_data
	);

endmodule

`default_nettype wire

// ==== sim/tb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
	output logic mem_read,
	output logic arst_n
);
	initial begin
		mem_read = 1'b0;
		forever #4 mem_read = !mem_read; // 8 ns period.
	end

	initial begin
		arst_n = 1'b0;
		repeat (2) @(posedge mem_read);
		#1 arst_n = 1'b1; // released just after an edge, like the other inputs.
	end

endmodule

`default_nettype wire

// ==== sim/tb_soc_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_soc_mem;
	import soc_mem_pkg::*;

	localparam int MEM_BYTES   = 4096;
	localparam int FRAME_WORD0 = (MEM_BYTES - FRAME_BYTES) / 4;
	localparam int UART_ADR    = MEM_BYTES - UART_OFFSET;
	localparam int FRAME_CYC   = H_TOTAL * V_TOTAL;
	localparam int WATCH_CYC   = 4 * FRAME_CYC + 3 * 10 * BAUD_DIV;

	logic        mem_read;
	logic        arst_n;
	logic        rx;
	logic [31:0] mem_size;
	logic        cpu_valid;
	cpu_req_t    cpu_req;
	logic        cpu_ready;
	cpu_rsp_t    cpu_rsp;
	logic        rd_en;
	logic        wr_en;
	logic [31:0] adr;
	logic [31:0] wdata;
	logic [3:0]  sel;
	logic        mem_busy;
	logic [31:0] rdata;
	logic        hsync_n;
	logic        vsync_n;
	logic        pixel_data;

	logic [7:0]  mem [MEM_BYTES];      // bus-side memory model.
	logic [31:0] exp_mem [MEM_BYTES/4]; // expected contents, word view.
	int          cur_frame;
	int          cur_v;
	int          error_count;
	logic        traffic_done;

	tb_clkgen i_tb_clkgen (.mem_read, .arst_n);

	soc_mem_top i_soc_mem_top (
		.mem_read, .arst_n, .rx, .mem_size, .cpu_valid, .cpu_req, .cpu_ready, .cpu_rsp,
		.rd_en, .wr_en, .adr, .wdata, .sel, .mem_busy, .rdata,
		.hsync_n, .vsync_n, .pixel_data
	);

	function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wd,
		input logic [3:0] s);
		logic [31:0] res;
		res = old;
		for (int i = 0; i < 4; i++)
			if (s[i])
				res[8*i +: 8] = wd[8*i +: 8];
		return res;
	endfunction

	function automatic logic exp_pixel(input int h, input int v, input int f);
		logic [31:0] w;
		if (h >= H_ACTIVE || v >= V_ACTIVE)
			return 1'b0;
		if (f == 0 && v == 0 && h < 32)
			return 1'b0; // first group after reset is never fetched.
		w = exp_mem[FRAME_WORD0 + v * 4 + h / 32];
		return w[h % 32];
	endfunction

	function automatic logic exp_hsync(input int h);
		return !(h >= H_SYNC_START && h < H_SYNC_END);
	endfunction

	function automatic logic exp_vsync(input int v);
		return !(v >= V_SYNC_START && v < V_SYNC_END);
	endfunction

	// flag in bit 8, byte below it.
	function automatic logic [31:0] uart_word(input uart_stat_t s);
		return {23'd0, s.is_new, s.data};
	endfunction

	function automatic logic [31:0] read_word(input logic [11:0] a);
		return {mem[a + 12'd3], mem[a + 12'd2], mem[a + 12'd1], mem[a]};
	endfunction

	task automatic fail_run(input string what);
		error_count++;
		$display("%s", what);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_rsp(input cpu_rsp_t got, input cpu_rsp_t exp, input string name);
		if (got !== exp)
			fail_run($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_video(input logic got, input logic exp, input string name);
		if (got !== exp)
			fail_run($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_uart(input uart_stat_t got, input uart_stat_t exp);
		if (got !== exp)
			fail_run($sformatf("** Error: uart_stat got 0x%h expected 0x%h", got, exp));
	endtask

	// starts and ends just after a rising edge.
	task automatic cpu_access(input logic wr, input logic [31:0] a, input logic [31:0] wd,
		input logic [3:0] s, output cpu_rsp_t rsp);
		logic took;
		took      = 1'b0;
		cpu_req   = '{write: wr, adr: a, wdata: wd, sel: s};
		cpu_valid = 1'b1;
		while (!took) begin
			@(negedge mem_read);
			took = cpu_ready;
			@(posedge mem_read);
			#1;
		end
		cpu_valid = 1'b0;
		@(negedge mem_read);
		while (!cpu_rsp.valid) begin
			if (cpu_ready)
				fail_run("cpu_ready rose while a CPU request was still outstanding");
			@(negedge mem_read);
		end
		rsp = cpu_rsp;
		@(negedge mem_read);
		if (cpu_rsp.valid)
			fail_run("a single CPU request produced two responses");
		@(posedge mem_read);
		#1;
	endtask

	task automatic do_write(input logic [31:0] a, input logic [31:0] wd, input logic [3:0] s);
		cpu_rsp_t rsp;
		if (a != UART_ADR)
			exp_mem[a[11:2]] = merge_bytes(exp_mem[a[11:2]], wd, s);
		cpu_access(1'b1, a, wd, s, rsp);
		check_rsp(rsp, '{valid: 1'b1, rdata: 32'd0}, "cpu_rsp (write)");
	endtask

	task automatic do_read(input logic [31:0] a);
		cpu_rsp_t rsp;
		cpu_access(1'b0, a, 32'd0, 4'hf, rsp);
		check_rsp(rsp, '{valid: 1'b1, rdata: exp_mem[a[11:2]]}, "cpu_rsp (read)");
	endtask

	task automatic uart_read(input uart_stat_t exp);
		cpu_rsp_t rsp;
		cpu_access(1'b0, UART_ADR, 32'd0, 4'hf, rsp);
		check_uart(uart_stat_t'(rsp.rdata[8:0]), exp);
		check_rsp(rsp, '{valid: 1'b1, rdata: uart_word(exp)}, "cpu_rsp (uart)");
	endtask

	// 8N1, lsb first.
	task automatic send_serial(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			rx = frame[i];
			repeat (BAUD_DIV) @(posedge mem_read);
			#1;
		end
	endtask

	// memory with random busy stretches of 0 to 3 cycles.
	initial begin : bus_model
		logic        complete;
		logic        wr_q;
		logic [31:0] a_q;
		logic [31:0] d_q;
		logic [3:0]  s_q;
		logic        in_acc;
		int          cnt;
		in_acc = 1'b0;
		cnt    = 0;
		forever begin
			@(negedge mem_read);
			complete = (rd_en || wr_en) && !mem_busy;
			wr_q     = wr_en;
			a_q      = adr;
			d_q      = wdata;
			s_q      = sel;
			@(posedge mem_read);
			if (complete) begin
				in_acc = 1'b0;
				if (wr_q)
					for (int i = 0; i < 4; i++)
						if (s_q[i])
							mem[a_q[11:0] + i] = d_q[8*i +: 8];
			end
			#1;
			if ((rd_en || wr_en) && !in_acc) begin
				in_acc = 1'b1;
				cnt    = $urandom % 4;
			end
			if ((rd_en || wr_en) && cnt > 0) begin
				mem_busy = 1'b1;
				cnt--;
			end else begin
				mem_busy = 1'b0;
				rdata    = rd_en ? read_word(adr[11:0]) : 32'd0;
			end
		end
	end

	// display compare over three frames; the counter starts at the first edge after reset.
	initial begin : video_check
		int h;
		int v;
		int f;
		wait (arst_n);
		for (int n = 0; n < 3 * FRAME_CYC; n++) begin
			@(posedge mem_read);
			@(negedge mem_read);
			h = n % H_TOTAL;
			v = (n / H_TOTAL) % V_TOTAL;
			f = n / FRAME_CYC;
			cur_frame = f;
			cur_v     = v;
			check_video(pixel_data, exp_pixel(h, v, f), "pixel_data");
			check_video(hsync_n, exp_hsync(h), "hsync_n");
			check_video(vsync_n, exp_vsync(v), "vsync_n");
		end
		wait (traffic_done);
		if (error_count == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	end

	initial begin : watchdog
		repeat (WATCH_CYC) @(posedge mem_read);
		$display("timeout: the run did not finish in %0d cycles", WATCH_CYC);
		$display("*** TEST FAILED ***");
		$fatal(1);
	end

	initial begin : cpu_driver
		logic [31:0] a;
		logic [31:0] wd;
		logic [7:0]  ub;
		logic [31:0] addrs [$];
		void'($urandom(32'h5e7d2c30));
		rx           = 1'b1;
		mem_size     = MEM_BYTES;
		cpu_valid    = 1'b0;
		cpu_req      = '0;
		mem_busy     = 1'b0;
		rdata        = 32'd0;
		cur_frame    = 0;
		cur_v        = 0;
		error_count  = 0;
		traffic_done = 1'b0;
		for (int i = 0; i < MEM_BYTES / 4; i++) begin
			wd         = $urandom;
			exp_mem[i] = wd;
			for (int j = 0; j < 4; j++)
				mem[4 * i + j] = wd[8*j +: 8];
		end

		// reset state.
		repeat (3) begin
			@(negedge mem_read);
			check_video(rd_en, 1'b0, "rd_en");
			check_video(wr_en, 1'b0, "wr_en");
			check_video(cpu_rsp.valid, 1'b0, "cpu_rsp.valid");
			check_video(pixel_data, 1'b0, "pixel_data");
			check_video(hsync_n, 1'b1, "hsync_n");
			check_video(vsync_n, 1'b1, "vsync_n");
		end
		@(posedge mem_read);
		#1;

		// write and readback below the frame buffer.
		for (int i = 0; i < 20; i++) begin
			a = ($urandom % FRAME_WORD0) * 4;
			addrs.push_back(a);
			do_write(a, $urandom, 4'($urandom));
		end
		foreach (addrs[i])
			do_read(addrs[i]);

		// uart status word.
		ub = 8'($urandom);
		send_serial(ub);
		repeat (4) @(posedge mem_read);
		#1;
		uart_read('{is_new: 1'b1, data: ub});
		uart_read('{is_new: 1'b0, data: ub});
		do_write(UART_ADR, $urandom, 4'hf);
		uart_read('{is_new: 1'b0, data: ub});
		do_read(UART_ADR - 4);

		// random traffic; frame writes only in the vertical blank of frame 1.
		while (cur_frame < 2) begin
			if (cur_frame == 1 && cur_v >= V_ACTIVE && cur_v <= V_SYNC_END) begin
				a = (FRAME_WORD0 + $urandom % (FRAME_BYTES / 4 - 1)) * 4; // skips the uart word.
				do_write(a, $urandom, 4'($urandom));
				do_read(a);
			end else if ($urandom % 2) begin
				do_write(($urandom % FRAME_WORD0) * 4, $urandom, 4'($urandom));
			end else begin
				do_read(($urandom % FRAME_WORD0) * 4);
			end
		end
		traffic_done = 1'b1;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
logic/soc_mem_pkg.sv
logic/uart_rx.sv
logic/vga_fetch.sv
logic/req_arbiter.sv
logic/mem_issue.sv
logic/resp_route.sv
logic/soc_mem_top.sv
sim/tb_clkgen.sv
sim/tb_soc_mem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
# The exit status is the simulator's, so a $fatal in the testbench fails this script.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f sim.f \
	--top-module tb_soc_mem \
	-Mdir obj_dir \
	-o tb_soc_mem_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/tb_soc_mem_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

echo "simulation finished with status 0"
exit 0
